// File: hdl/clock_pkg.sv
package clock_pkg;

	// --------------------------------------------------
	// Limits and sizes
	// --------------------------------------------------
	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HOUR_MAX = 6'd23;
	localparam int NUM_DIGITS = 6;

	// --------------------------------------------------
	// Control state
	// --------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} clock_mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC = 2'd0,
		FIELD_MIN = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	// --------------------------------------------------
	// Time, requests and buttons
	// --------------------------------------------------
	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
	} hms_inc_t;

	typedef struct packed {
		logic mode;
		logic field;
		logic incr;
		logic alarm;
	} btn_t;

	// Segment a in bit 6 down to segment g in bit 0
	typedef logic [6:0] seg_t;

	// Index 0 is seconds ones, index 5 is hours tens
	typedef seg_t [NUM_DIGITS-1:0] panel_t;

endpackage

// File: hdl/button_sync.sv
module button_sync #(
	parameter int SAMPLE_DIV = 500000
) (
	input  logic i_btn_mode,
	input  logic i_btn_field,
	input  logic i_btn_incr,
	input  logic i_btn_alarm,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::btn_t o_press
);

	localparam int CNT_W = $clog2(SAMPLE_DIV + 1);

	logic [CNT_W-1:0] sample_cnt;
	logic sample_en;
	clock_pkg::btn_t raw;
	clock_pkg::btn_t samp_0;
	clock_pkg::btn_t samp_1;
	clock_pkg::btn_t stable;
	clock_pkg::btn_t level;
	clock_pkg::btn_t level_d;

	assign raw = '{mode: i_btn_mode, field: i_btn_field, incr: i_btn_incr, alarm: i_btn_alarm};

	// Debounce sample rate
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
		end else if (sample_en) begin
			sample_cnt <= '0;
		end else begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	assign sample_en = (sample_cnt == CNT_W'(SAMPLE_DIV - 1));

	// Two samples that agree set the level
	assign stable = ~(samp_0 ^ samp_1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_0 <= '0;
			samp_1 <= '0;
			level <= '0;
			level_d <= '0;
		end else begin
			if (sample_en) begin
				samp_0 <= raw;
				samp_1 <= samp_0;
			end
			level <= (level & ~stable) | (samp_0 & stable);
			level_d <= level;
		end
	end

	// Rising edge of the debounced level
	assign o_press = level & ~level_d;

	// A press comes one cycle after the samples update
	a_press_after_sample : assert property (@(posedge clk) disable iff (!rst_n)
		(|o_press) |-> (sample_cnt == CNT_W'(1 % SAMPLE_DIV)));

endmodule

// File: hdl/clock_ctrl.sv
module clock_ctrl #(
	parameter int TICK_DIV = 50000000
) (
	input  clock_pkg::btn_t i_press,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::clock_mode_e o_mode,
	output logic o_alarm_en,
	output clock_pkg::hms_inc_t o_time_inc,
	output clock_pkg::hms_inc_t o_alarm_inc
);

	localparam int CNT_W = $clog2(TICK_DIV + 1);

	logic [CNT_W-1:0] tick_cnt;
	logic tick;
	clock_pkg::field_e field;
	clock_pkg::hms_inc_t sel_inc;

	// --------------------------------------------------
	// Mode, field and alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= clock_pkg::MODE_CLOCK;
			field <= clock_pkg::FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default: o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_press.field) begin
				case (field)
					clock_pkg::FIELD_SEC: field <= clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: field <= clock_pkg::FIELD_HOUR;
					default: field <= clock_pkg::FIELD_SEC;
				endcase
			end
			if (i_press.alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// --------------------------------------------------
	// One-second tick
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

	// Incr press routed to the selected field
	assign sel_inc.sec = i_press.incr && (field == clock_pkg::FIELD_SEC);
	assign sel_inc.min = i_press.incr && (field == clock_pkg::FIELD_MIN);
	assign sel_inc.hour = i_press.incr && (field == clock_pkg::FIELD_HOUR);

	always_comb begin
		o_time_inc = '0;
		o_alarm_inc = '0;
		case (o_mode)
			clock_pkg::MODE_SETUP: begin
				o_time_inc = sel_inc;
			end
			clock_pkg::MODE_ALARM: begin
				o_time_inc.sec = tick;
				o_alarm_inc = sel_inc;
			end
			default: begin
				o_time_inc.sec = tick;
			end
		endcase
	end

	a_mode_legal : assert property (@(posedge clk) disable iff (!rst_n)
		o_mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SETUP, clock_pkg::MODE_ALARM});

endmodule

// File: hdl/hms_counter.sv
module hms_counter #(
	parameter bit CARRY_EN = 1'b1
) (
	input  clock_pkg::hms_inc_t i_inc,
	input  logic i_carry_en,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::hms_t o_time
);

	logic sec_wrap;
	logic sec_carry;
	logic min_step;
	logic min_wrap;
	logic hour_step;
	logic hour_wrap;

	// Carries ripple within the same cycle
	assign sec_wrap = i_inc.sec && (o_time.sec == clock_pkg::SEC_MAX);
	assign sec_carry = CARRY_EN && i_carry_en && sec_wrap;
	assign min_step = i_inc.min || sec_carry;
	assign min_wrap = o_time.min == clock_pkg::MIN_MAX;
	assign hour_step = i_inc.hour || (sec_carry && min_wrap);
	assign hour_wrap = o_time.hour == clock_pkg::HOUR_MAX;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else begin
			if (i_inc.sec) begin
				o_time.sec <= sec_wrap ? 6'd0 : o_time.sec + 6'd1;
			end
			if (min_step) begin
				o_time.min <= min_wrap ? 6'd0 : o_time.min + 6'd1;
			end
			if (hour_step) begin
				o_time.hour <= hour_wrap ? 6'd0 : o_time.hour + 6'd1;
			end
		end
	end

	a_field_range : assert property (@(posedge clk) disable iff (!rst_n)
		(o_time.sec <= clock_pkg::SEC_MAX) &&
		(o_time.min <= clock_pkg::MIN_MAX) &&
		(o_time.hour <= clock_pkg::HOUR_MAX));

endmodule

// File: hdl/alarm_unit.sv
module alarm_unit (
	input  clock_pkg::hms_t i_time,
	input  clock_pkg::hms_inc_t i_alarm_inc,
	input  logic i_alarm_en,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::hms_t o_alarm_time,
	output logic o_alarm
);

	logic time_match;

	// Alarm time is set field by field without carry
	hms_counter #(
		.CARRY_EN(1'b0)
	) alarm_cnt_i (
		.i_inc(i_alarm_inc),
		.i_carry_en(1'b0),
		.clk(clk),
		.rst_n(rst_n),
		.o_time(o_alarm_time)
	);

	assign time_match = (i_time == o_alarm_time);

	// Flag holds until the alarm is switched off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm <= 1'b0;
		end else if (time_match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

// File: hdl/digit_encode.sv
module digit_encode (
	input  clock_pkg::hms_t i_time,
	output clock_pkg::panel_t o_panel
);

	logic [5:0] field_val [3];

	// Seven-segment table, segment a in the top bit
	function automatic clock_pkg::seg_t seg_of(input logic [3:0] digit);
		case (digit)
			4'd0: seg_of = 7'b111_1110;
			4'd1: seg_of = 7'b011_0000;
			4'd2: seg_of = 7'b110_1101;
			4'd3: seg_of = 7'b111_1001;
			4'd4: seg_of = 7'b011_0011;
			4'd5: seg_of = 7'b101_1011;
			4'd6: seg_of = 7'b101_1111;
			4'd7: seg_of = 7'b111_0000;
			4'd8: seg_of = 7'b111_1111;
			4'd9: seg_of = 7'b111_0011;
			default: seg_of = 7'b000_0000;
		endcase
	endfunction

	assign field_val[0] = i_time.sec;
	assign field_val[1] = i_time.min;
	assign field_val[2] = i_time.hour;

	// Ones digit at the even index, tens at the odd one
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			o_panel[2*i] = seg_of(4'(field_val[i] % 6'd10));
			o_panel[2*i+1] = seg_of(4'(field_val[i] / 6'd10));
		end
	end

endmodule

// File: hdl/display_scan.sv
module display_scan #(
	parameter int SCAN_DIV = 5000
) (
	input  clock_pkg::panel_t i_panel,
	input  clock_pkg::clock_mode_e i_mode,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::seg_t o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic o_seg_dp
);

	localparam int CNT_W = $clog2(SCAN_DIV + 1);
	localparam int IDX_W = $clog2(clock_pkg::NUM_DIGITS);

	logic [CNT_W-1:0] dwell_cnt;
	logic dwell_end;
	logic [IDX_W-1:0] digit_idx;
	logic dp_on;

	assign dwell_end = (dwell_cnt == CNT_W'(SCAN_DIV - 1));

	// --------------------------------------------------
	// Dwell counter and digit index
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dwell_cnt <= '0;
			digit_idx <= '0;
		end else if (dwell_end) begin
			dwell_cnt <= '0;
			if (digit_idx == IDX_W'(clock_pkg::NUM_DIGITS - 1)) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	// Mode shown on the decimal points
	assign dp_on = ((i_mode == clock_pkg::MODE_SETUP) && (digit_idx == IDX_W'(0))) ||
		((i_mode == clock_pkg::MODE_ALARM) && (digit_idx == IDX_W'(1)));

	// --------------------------------------------------
	// Output registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg_enb <= '1;
			o_seg_dp <= 1'b0;
		end else begin
			o_seg_enb <= ~(clock_pkg::NUM_DIGITS'(1) << digit_idx);
			o_seg_dp <= dp_on;
		end
	end

	always_ff @(posedge clk) begin
		o_seg <= i_panel[digit_idx];
	end

	a_one_digit_on : assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> $onehot(~o_seg_enb));

endmodule

// File: hdl/digital_clock_top.sv
module digital_clock_top #(
	parameter int TICK_DIV = 50000000,
	parameter int SAMPLE_DIV = 500000,
	parameter int SCAN_DIV = 5000
) (
	input  logic i_btn_mode,
	input  logic i_btn_field,
	input  logic i_btn_incr,
	input  logic i_btn_alarm,
	input  logic clk,
	input  logic rst_n,
	output clock_pkg::seg_t o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic o_seg_dp,
	output logic o_alarm
);

	clock_pkg::btn_t press;
	clock_pkg::clock_mode_e mode;
	logic alarm_en;
	logic run_carry;
	clock_pkg::hms_inc_t time_inc;
	clock_pkg::hms_inc_t alarm_inc;
	clock_pkg::hms_t run_time;
	clock_pkg::hms_t alarm_time;
	clock_pkg::hms_t show_time;
	clock_pkg::panel_t panel;

	// --------------------------------------------------
	// Input side and control
	// --------------------------------------------------
	button_sync #(.SAMPLE_DIV(SAMPLE_DIV)) button_sync_i (
		.i_btn_mode(i_btn_mode),
		.i_btn_field(i_btn_field),
		.i_btn_incr(i_btn_incr),
		.i_btn_alarm(i_btn_alarm),
		.clk(clk),
		.rst_n(rst_n),
		.o_press(press)
	);

	clock_ctrl #(.TICK_DIV(TICK_DIV)) clock_ctrl_i (
		.i_press(press),
		.clk(clk),
		.rst_n(rst_n),
		.o_mode(mode),
		.o_alarm_en(alarm_en),
		.o_time_inc(time_inc),
		.o_alarm_inc(alarm_inc)
	);

	// Running time carries only while it runs
	assign run_carry = (mode != clock_pkg::MODE_SETUP);

	hms_counter #(.CARRY_EN(1'b1)) hms_counter_i (
		.i_inc(time_inc),
		.i_carry_en(run_carry),
		.clk(clk),
		.rst_n(rst_n),
		.o_time(run_time)
	);

	alarm_unit alarm_unit_i (
		.i_time(run_time),
		.i_alarm_inc(alarm_inc),
		.i_alarm_en(alarm_en),
		.clk(clk),
		.rst_n(rst_n),
		.o_alarm_time(alarm_time),
		.o_alarm(o_alarm)
	);

	// --------------------------------------------------
	// Output side
	// --------------------------------------------------
	assign show_time = (mode == clock_pkg::MODE_ALARM) ? alarm_time : run_time;

	digit_encode digit_encode_i (
		.i_time(show_time),
		.o_panel(panel)
	);

	display_scan #(.SCAN_DIV(SCAN_DIV)) display_scan_i (
		.i_panel(panel),
		.i_mode(mode),
		.clk(clk),
		.rst_n(rst_n),
		.o_seg(o_seg),
		.o_seg_enb(o_seg_enb),
		.o_seg_dp(o_seg_dp)
	);

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: test/tb_digital_clock.sv
module tb_digital_clock;

	localparam int HOLD_CYCLES = 16;
	localparam int DIGIT_TIMEOUT = 64;
	localparam int SETTLE_TRIES = 4;
	localparam int RESET_TIMEOUT = 100;

	logic clk;
	logic rst_n;
	logic btn_mode;
	logic btn_field;
	logic btn_incr;
	logic btn_alarm;
	logic [6:0] seg;
	logic [5:0] seg_enb;
	logic seg_dp;
	logic alarm;

	integer seed;
	integer check_count;
	integer cycle_count = 0;

	tb_clock_gen clock_gen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	digital_clock_top #(
		.TICK_DIV(200),
		.SAMPLE_DIV(4),
		.SCAN_DIV(4)
	) digital_clock_top_i (
		.i_btn_mode(btn_mode),
		.i_btn_field(btn_field),
		.i_btn_incr(btn_incr),
		.i_btn_alarm(btn_alarm),
		.clk(clk),
		.rst_n(rst_n),
		.o_seg(seg),
		.o_seg_enb(seg_enb),
		.o_seg_dp(seg_dp),
		.o_alarm(alarm)
	);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// --------------------------------------------------
	// Checking and failure
	// --------------------------------------------------
	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("ERROR: time %0t: %s is %h, expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	// Segment a in the top bit, 4'hf for an unknown pattern
	function automatic logic [3:0] decode_segment(input logic [6:0] pattern);
		case (pattern)
			7'b1111110: decode_segment = 4'd0;
			7'b0110000: decode_segment = 4'd1;
			7'b1101101: decode_segment = 4'd2;
			7'b1111001: decode_segment = 4'd3;
			7'b0110011: decode_segment = 4'd4;
			7'b1011011: decode_segment = 4'd5;
			7'b1011111: decode_segment = 4'd6;
			7'b1110000: decode_segment = 4'd7;
			7'b1111111: decode_segment = 4'd8;
			7'b1110011: decode_segment = 4'd9;
			default: decode_segment = 4'hf;
		endcase
	endfunction

	// --------------------------------------------------
	// Display reading
	// --------------------------------------------------
	task automatic wait_digit_enable(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (seg_enb !== ~(6'b000001 << idx)) begin
			if (waited >= DIGIT_TIMEOUT) begin
				$display("Enable of digit %0d did not go low within %0d cycles", idx,
					DIGIT_TIMEOUT);
				abort_run();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic read_panel(output logic [23:0] digits, output logic [5:0] dps);
		for (int idx = 0; idx < 6; idx++) begin
			wait_digit_enable(idx);
			digits[4*idx +: 4] = decode_segment(seg);
			dps[idx] = seg_dp;
		end
	endtask

	// Time may step between scans, so two scans must agree
	task automatic read_display(output logic [23:0] digits, output logic [5:0] dps);
		logic [23:0] prev_digits;
		logic [5:0] prev_dps;
		int tries;
		read_panel(prev_digits, prev_dps);
		read_panel(digits, dps);
		tries = 1;
		while ((digits !== prev_digits) || (dps !== prev_dps)) begin
			if (tries >= SETTLE_TRIES) begin
				$display("Display did not read the same twice in %0d tries", SETTLE_TRIES);
				abort_run();
			end
			prev_digits = digits;
			prev_dps = dps;
			read_panel(digits, dps);
			tries++;
		end
	endtask

	task automatic expect_display(input logic [23:0] exp_digits, input logic [1:0] exp_dp,
			input int wait_cycles);
		logic [23:0] digits;
		logic [5:0] dps;
		int start;
		start = cycle_count;
		read_display(digits, dps);
		while ((digits !== exp_digits) && (cycle_count - start < wait_cycles)) begin
			read_display(digits, dps);
		end
		check_value("display digits", 32'(digits), 32'(exp_digits));
		check_value("decimal points", 32'(dps), 32'(exp_dp));
	endtask

	task automatic expect_alarm(input logic level, input int timeout, input int hold);
		int waited;
		waited = 0;
		@(negedge clk);
		while ((alarm !== level) && (waited < timeout)) begin
			@(negedge clk);
			waited++;
		end
		check_value("o_alarm", 32'(alarm), 32'(level));
		repeat (hold) begin
			@(negedge clk);
			check_value("o_alarm", 32'(alarm), 32'(level));
		end
	endtask

	// --------------------------------------------------
	// Button driving
	// --------------------------------------------------
	task automatic press_button(input logic [63:0] name, input int count);
		logic [3:0] sel;
		int delay;
		sel = 4'b0000;
		if (name == "mode") begin
			sel = 4'b1000;
		end else if (name == "field") begin
			sel = 4'b0100;
		end else if (name == "incr") begin
			sel = 4'b0010;
		end else if (name == "alarm") begin
			sel = 4'b0001;
		end else begin
			$display("Unknown button name %0s in the stimulus file", name);
			abort_run();
		end
		repeat (count) begin
			delay = $unsigned($random(seed)) % 4;
			repeat (delay) @(negedge clk);
			@(negedge clk);
			{btn_mode, btn_field, btn_incr, btn_alarm} = sel;
			repeat (HOLD_CYCLES) @(negedge clk);
			{btn_mode, btn_field, btn_incr, btn_alarm} = 4'b0000;
			repeat (HOLD_CYCLES) @(negedge clk);
		end
	endtask

	task automatic report_bad_line(input logic [63:0] cmd);
		$display("Malformed %0s line in the stimulus file", cmd);
		abort_run();
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		integer fd;
		integer code;
		integer ch;
		integer num_a;
		integer num_b;
		integer num_c;
		int waited;
		logic [63:0] cmd;
		logic [63:0] arg;
		logic [23:0] digits;
		logic [1:0] dp;

		btn_mode = 1'b0;
		btn_field = 1'b0;
		btn_incr = 1'b0;
		btn_alarm = 1'b0;
		seed = 32'h225cde3b;
		check_count = 0;

		fd = $fopen("test/clock_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file test/clock_stim.txt");
			abort_run();
		end

		waited = 0;
		while (rst_n !== 1'b1) begin
			if (waited >= RESET_TIMEOUT) begin
				$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
				abort_run();
			end
			@(negedge clk);
			waited++;
		end

		code = $fscanf(fd, "%s", cmd);
		while (code == 1) begin
			if (cmd == "#") begin
				// Skip the rest of a comment line
				ch = $fgetc(fd);
				while ((ch != 10) && (ch != -1)) begin
					ch = $fgetc(fd);
				end
			end else if (cmd == "press") begin
				code = $fscanf(fd, "%s %d", arg, num_a);
				if (code != 2) begin
					report_bad_line(cmd);
				end
				press_button(arg, num_a);
			end else if (cmd == "expect") begin
				code = $fscanf(fd, "%h %b %d", digits, dp, num_a);
				if (code != 3) begin
					report_bad_line(cmd);
				end
				expect_display(digits, dp, num_a);
			end else if (cmd == "alarm") begin
				code = $fscanf(fd, "%d %d %d", num_a, num_b, num_c);
				if (code != 3) begin
					report_bad_line(cmd);
				end
				expect_alarm(num_a[0], num_b, num_c);
			end else begin
				report_bad_line(cmd);
			end
			code = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);

		if (check_count == 0) begin
			$display("No checks ran, the stimulus file held no expected values");
			abort_run();
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: test/clock_stim.txt
# press <button> <times> | expect <hhmmss> <dp of digit 1, digit 0> <max wait cycles>
# alarm <level> <max wait cycles> <cycles the level must hold>
expect 000000 00 0
alarm 0 0 0
press mode 1
expect 000000 01 0
press incr 61
expect 000001 01 0
press field 2
press incr 23
expect 230001 01 0
press incr 1
expect 000001 01 0
press field 1
press mode 1
expect 000000 10 0
press incr 8
expect 000008 10 0
press mode 1
expect 000006 00 1500
alarm 0 0 600
expect 000010 00 1000
press mode 1
expect 000010 01 0
press incr 49
expect 000059 01 0
press mode 2
expect 000100 00 1000
press mode 2
press field 1
press incr 1
expect 000108 10 0
press mode 1
press alarm 1
alarm 1 3000 0
press alarm 1
alarm 0 100 400

// File: tb.f
hdl/clock_pkg.sv
hdl/button_sync.sv
hdl/clock_ctrl.sv
hdl/hms_counter.sv
hdl/alarm_unit.sv
hdl/digit_encode.sv
hdl/display_scan.sv
hdl/digital_clock_top.sv
test/tb_clock_gen.sv
test/tb_digital_clock.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_digital_clock
FILE_LIST ?= tb.f
OBJ_DIR ?= obj_dir
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# Pass or fail is decided by the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
